//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ==========================================================================
  // opcodes and instruction formats
  // ==========================================================================
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // opcode kept as raw bits, unknown values must still decode
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } insn_u;

  // ==========================================================================
  // control word
  // ==========================================================================
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;
  typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    logic      op_b_imm;   // 1: immediate, 0: rs2
    logic      rd_wren;
    logic      mem_wren;
    logic      mem_rden;
    wb_sel_e   wb_sel;
    logic      br_unsign;
    logic      is_branch;
    logic      is_jump;
    logic      insn_vld;
  } ctrl_t;

  // ==========================================================================
  // board io
  // ==========================================================================
  typedef struct packed {
    logic [31:0]     ledr;
    logic [31:0]     ledg;
    logic [31:0]     lcd;
    logic [7:0][6:0] hex;  // hex[0] is the rightmost digit
  } board_io_t;

  parameter logic [31:0] IO_BASE       = 32'h1000_0000;
  parameter logic [31:0] IO_SW_ADDR    = 32'h1000_0000;
  parameter logic [31:0] IO_LEDR_ADDR  = 32'h1000_1000;
  parameter logic [31:0] IO_LEDG_ADDR  = 32'h1000_2000;
  parameter logic [31:0] IO_LCD_ADDR   = 32'h1000_3000;
  parameter logic [31:0] IO_HEXLO_ADDR = 32'h1000_4000;
  parameter logic [31:0] IO_HEXHI_ADDR = 32'h1000_5000;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
  import rv_pkg::*;
#(
  parameter int IMEM_WORDS = 256
) (
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire         i_pc_take,
  input  wire  [31:0] i_target,
  output logic [31:0] o_pc,
  output logic [31:0] o_pc_plus4,
  output insn_u       o_insn
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  logic [31:0] imem [IMEM_WORDS];  // instruction rom
  logic [31:0] pc_q;
  logic [31:0] pc_next;

  initial begin
    $readmemh("rv_prog.hex", imem);
  end

  assign o_pc_plus4 = pc_q + 32'd4;
  // jalr target may have bit 0 set
  assign pc_next    = i_pc_take ? {i_target[31:1], 1'b0} : o_pc_plus4;

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      pc_q <= 32'd0;  // boot from address 0
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc   = pc_q;
  assign o_insn = imem[pc_q[IDX_W+1:2]];  // word index

endmodule

`default_nettype wire

//--- rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control
  import rv_pkg::*;
(
  input  insn_u     i_insn,
  input  wire       i_br_equal,
  input  wire       i_br_less,
  output ctrl_t     o_ctrl,
  output mem_size_e o_size,
  output logic      o_ld_unsign,
  output logic      o_pc_take
);

  logic [2:0] funct3;
  logic       alt;       // funct7 bit 5, sub / sra
  logic       br_cond;

  // funct3 to alu op, shared by reg and imm forms
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_ok,
                                         input logic f7_alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = (sub_ok && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = i_insn.r.funct3;
  assign alt    = i_insn.r.funct7[5];

  // ==========================================================================
  // main decode
  // ==========================================================================
  always_comb begin
    // no-op defaults, nothing written
    o_ctrl.alu_op    = ALU_ADD;
    o_ctrl.op_a_sel  = OPA_RS1;
    o_ctrl.op_b_imm  = 1'b0;
    o_ctrl.rd_wren   = 1'b0;
    o_ctrl.mem_wren  = 1'b0;
    o_ctrl.mem_rden  = 1'b0;
    o_ctrl.wb_sel    = WB_ALU;
    o_ctrl.br_unsign = funct3[1];  // bltu / bgeu
    o_ctrl.is_branch = 1'b0;
    o_ctrl.is_jump   = 1'b0;
    o_ctrl.insn_vld  = 1'b1;
    case (i_insn.r.opcode)
      OPC_OP: begin
        o_ctrl.alu_op  = alu_decode(funct3, 1'b1, alt);
        o_ctrl.rd_wren = 1'b1;
      end
      OPC_OP_IMM: begin
        o_ctrl.alu_op   = alu_decode(funct3, 1'b0, alt);  // no subi
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wren  = 1'b1;
      end
      OPC_LOAD: begin
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.mem_rden = 1'b1;
        o_ctrl.rd_wren  = 1'b1;
        o_ctrl.wb_sel   = WB_LOAD;
      end
      OPC_STORE: begin
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.mem_wren = 1'b1;
      end
      OPC_BRANCH: begin
        o_ctrl.op_a_sel  = OPA_PC;  // alu forms pc + imm
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.is_branch = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // jal adds to pc, jalr adds to rs1
        o_ctrl.op_a_sel = (i_insn.r.opcode == OPC_JAL) ? OPA_PC : OPA_RS1;
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wren  = 1'b1;
        o_ctrl.wb_sel   = WB_PC4;   // link address
        o_ctrl.is_jump  = 1'b1;
      end
      OPC_LUI: begin
        o_ctrl.op_a_sel = OPA_ZERO;
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.rd_wren  = 1'b1;
      end
      OPC_AUIPC: begin
        o_ctrl.op_a_sel = OPA_PC;
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wren  = 1'b1;
      end
      default: o_ctrl.insn_vld = 1'b0;  // unsupported, acts as nop
    endcase
  end

  // size and sign straight from funct3
  always_comb begin
    case (funct3[1:0])
      2'b00:   o_size = SIZE_BYTE;
      2'b01:   o_size = SIZE_HALF;
      default: o_size = SIZE_WORD;
    endcase
  end
  assign o_ld_unsign = funct3[2];  // lbu / lhu

  // ==========================================================================
  // branch decision
  // ==========================================================================
  always_comb begin
    case (funct3)
      3'b000:         br_cond = i_br_equal;   // beq
      3'b001:         br_cond = !i_br_equal;  // bne
      3'b100, 3'b110: br_cond = i_br_less;    // blt, bltu
      3'b101, 3'b111: br_cond = !i_br_less;   // bge, bgeu
      default:        br_cond = 1'b0;
    endcase
  end

  assign o_pc_take = o_ctrl.is_jump || (o_ctrl.is_branch && br_cond);

endmodule

`default_nettype wire

//--- rv_immgen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_immgen
  import rv_pkg::*;
(
  input  insn_u       i_insn,
  output logic [31:0] o_imm
);

  logic sgn;  // every format keeps its sign in bit 31

  assign sgn = i_insn.r.funct7[6];

  always_comb begin
    case (i_insn.r.opcode)
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        o_imm = {{20{sgn}}, i_insn.i.imm_11_0};
      OPC_STORE:
        o_imm = {{20{sgn}}, i_insn.s.imm_11_5, i_insn.s.imm_4_0};
      OPC_BRANCH:
        o_imm = {{19{sgn}}, i_insn.b.imm_12, i_insn.b.imm_11,
                 i_insn.b.imm_10_5, i_insn.b.imm_4_1, 1'b0};
      OPC_LUI, OPC_AUIPC:
        o_imm = {i_insn.u.imm_31_12, 12'd0};  // upper, no extension needed
      OPC_JAL:
        o_imm = {{11{sgn}}, i_insn.j.imm_20, i_insn.j.imm_19_12,
                 i_insn.j.imm_11, i_insn.j.imm_10_1, 1'b0};
      default:
        o_imm = 32'd0;  // r-type and unknown
    endcase
  end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire  [4:0]  i_rs1_addr,
  input  wire  [4:0]  i_rs2_addr,
  input  wire  [4:0]  i_rd_addr,
  input  wire  [31:0] i_rd_data,
  input  wire         i_rd_wren,
  output logic [31:0] o_rs1_data,
  output logic [31:0] o_rs2_data
);

  logic [31:1][31:0] regs_q;  // x1..x31, x0 not stored

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      regs_q <= '0;
    end else if (i_rd_wren && (i_rd_addr != 5'd0)) begin
      regs_q[i_rd_addr] <= i_rd_data;
    end
  end

  // async reads
  assign o_rs1_data = (i_rs1_addr == 5'd0) ? 32'd0 : regs_q[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? 32'd0 : regs_q[i_rs2_addr];

endmodule

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  wire  [31:0] i_op_a,
  input  wire  [31:0] i_op_b,
  input  alu_op_e     i_alu_op,
  input  wire  [31:0] i_rs1_data,
  input  wire  [31:0] i_rs2_data,
  input  wire         i_br_unsign,
  output logic [31:0] o_result,
  output logic        o_br_equal,
  output logic        o_br_less
);

  logic [4:0] shamt;
  logic       lt_s;  // signed a < b
  logic       lt_u;

  assign shamt = i_op_b[4:0];
  assign lt_s  = $signed(i_op_a) < $signed(i_op_b);
  assign lt_u  = i_op_a < i_op_b;

  // ==========================================================================
  // datapath
  // ==========================================================================
  always_comb begin
    case (i_alu_op)
      ALU_ADD:    o_result = i_op_a + i_op_b;
      ALU_SUB:    o_result = i_op_a - i_op_b;
      ALU_SLL:    o_result = i_op_a << shamt;
      ALU_SLT:    o_result = {31'd0, lt_s};
      ALU_SLTU:   o_result = {31'd0, lt_u};
      ALU_XOR:    o_result = i_op_a ^ i_op_b;
      ALU_SRL:    o_result = i_op_a >> shamt;
      ALU_SRA:    o_result = $unsigned($signed(i_op_a) >>> shamt);
      ALU_OR:     o_result = i_op_a | i_op_b;
      ALU_AND:    o_result = i_op_a & i_op_b;
      ALU_PASS_B: o_result = i_op_b;  // lui
      default:    o_result = 32'd0;
    endcase
  end

  // ==========================================================================
  // branch compare, always rs1 vs rs2
  // ==========================================================================
  assign o_br_equal = (i_rs1_data == i_rs2_data);

  always_comb begin
    if (i_br_unsign) begin
      o_br_less = i_rs1_data < i_rs2_data;
    end else begin
      o_br_less = $signed(i_rs1_data) < $signed(i_rs2_data);
    end
  end

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
  import rv_pkg::*;
#(
  parameter int DMEM_WORDS = 1024
) (
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire  [31:0] i_addr,
  input  wire  [31:0] i_st_data,
  input  wire         i_wren,
  input  wire         i_rden,
  input  mem_size_e   i_size,
  input  wire         i_ld_unsign,
  input  wire  [31:0] i_io_sw,
  output logic [31:0] o_ld_data,
  output board_io_t   o_io
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [31:0]      dmem [DMEM_WORDS];
  board_io_t        io_q;
  logic             is_io;
  logic [19:0]      page;       // io register select, 4 KB pages
  logic [3:0]       be;         // byte enables for ram
  logic [31:0]      st_lanes;   // store data replicated to every lane
  logic [31:0]      io_wdata;   // store data masked to size
  logic [31:0]      rd_word;
  logic [31:0]      rd_lane;
  logic [IDX_W-1:0] widx;

  assign is_io = (i_addr[31:28] == IO_BASE[31:28]);
  assign page  = i_addr[31:12];
  assign widx  = i_addr[IDX_W+1:2];

  // ==========================================================================
  // store lanes
  // ==========================================================================
  always_comb begin
    case (i_size)
      SIZE_BYTE: begin
        be       = 4'b0001 << i_addr[1:0];
        st_lanes = {4{i_st_data[7:0]}};
        io_wdata = {24'd0, i_st_data[7:0]};
      end
      SIZE_HALF: begin
        be       = 4'b0011 << {i_addr[1], 1'b0};
        st_lanes = {2{i_st_data[15:0]}};
        io_wdata = {16'd0, i_st_data[15:0]};
      end
      default: begin
        be       = 4'b1111;
        st_lanes = i_st_data;
        io_wdata = i_st_data;
      end
    endcase
  end

  // data ram, word wide with byte enables
  always_ff @(posedge i_clk) begin
    if (i_wren && !is_io) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) dmem[widx][8*b +: 8] <= st_lanes[8*b +: 8];
      end
    end
  end

  // io output registers
  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      io_q <= '0;  // board dark after reset
    end else if (i_wren && is_io) begin
      case (page)
        IO_LEDR_ADDR[31:12]: io_q.ledr <= io_wdata;
        IO_LEDG_ADDR[31:12]: io_q.ledg <= io_wdata;
        IO_LCD_ADDR[31:12]:  io_q.lcd  <= io_wdata;
        IO_HEXLO_ADDR[31:12]: begin
          for (int d = 0; d < 4; d++) io_q.hex[d] <= io_wdata[8*d +: 7];
        end
        IO_HEXHI_ADDR[31:12]: begin
          for (int d = 0; d < 4; d++) io_q.hex[d+4] <= io_wdata[8*d +: 7];
        end
        default: ;  // writes to sw page dropped
      endcase
    end
  end

  assign o_io = io_q;

  // ==========================================================================
  // loads, combinational
  // ==========================================================================
  assign rd_word = is_io ? ((page == IO_SW_ADDR[31:12]) ? i_io_sw : 32'd0)
                         : dmem[widx];
  assign rd_lane = rd_word >> {i_addr[1:0], 3'b000};  // selected lane to bit 0

  always_comb begin
    if (!i_rden) begin
      o_ld_data = 32'd0;
    end else begin
      case (i_size)
        SIZE_BYTE: o_ld_data = {{24{rd_lane[7] & !i_ld_unsign}}, rd_lane[7:0]};
        SIZE_HALF: o_ld_data = {{16{rd_lane[15] & !i_ld_unsign}}, rd_lane[15:0]};
        default:   o_ld_data = rd_lane;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 1024
) (
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire  [31:0] i_io_sw,
  output board_io_t   o_io,
  output logic [31:0] o_pc_debug,
  output logic        o_insn_vld
);

  logic [31:0] pc, pc_plus4, imm;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] op_a, op_b, alu_result;
  logic [31:0] ld_data, wb_data;
  logic        br_equal, br_less, pc_take, ld_unsign;
  insn_u       insn;
  ctrl_t       ctrl;
  mem_size_e   size;

  // ==========================================================================
  // fetch and decode
  // ==========================================================================
  rv_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .i_clk(i_clk), .i_reset(i_reset), .i_pc_take(pc_take), .i_target(alu_result),
    .o_pc(pc), .o_pc_plus4(pc_plus4), .o_insn(insn)
  );

  rv_control u_control (
    .i_insn(insn), .i_br_equal(br_equal), .i_br_less(br_less),
    .o_ctrl(ctrl), .o_size(size), .o_ld_unsign(ld_unsign), .o_pc_take(pc_take)
  );

  rv_immgen u_immgen (.i_insn(insn), .o_imm(imm));

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_rs1_addr(insn.r.rs1), .i_rs2_addr(insn.r.rs2), .i_rd_addr(insn.r.rd),
    .i_rd_data(wb_data), .i_rd_wren(ctrl.rd_wren),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  // ==========================================================================
  // execute, memory, writeback
  // ==========================================================================
  always_comb begin
    case (ctrl.op_a_sel)
      OPA_PC:   op_a = pc;     // branch, jal, auipc
      OPA_ZERO: op_a = 32'd0;  // lui
      default:  op_a = rs1_data;
    endcase
  end
  assign op_b = ctrl.op_b_imm ? imm : rs2_data;

  rv_alu u_alu (
    .i_op_a(op_a), .i_op_b(op_b), .i_alu_op(ctrl.alu_op),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_br_unsign(ctrl.br_unsign),
    .o_result(alu_result), .o_br_equal(br_equal), .o_br_less(br_less)
  );

  rv_lsu #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
    .i_clk(i_clk), .i_reset(i_reset), .i_addr(alu_result), .i_st_data(rs2_data),
    .i_wren(ctrl.mem_wren), .i_rden(ctrl.mem_rden), .i_size(size),
    .i_ld_unsign(ld_unsign), .i_io_sw(i_io_sw), .o_ld_data(ld_data), .o_io(o_io)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = ld_data;
      WB_PC4:  wb_data = pc_plus4;  // link for jal / jalr
      default: wb_data = alu_result;
    endcase
  end

  assign o_pc_debug = pc;
  assign o_insn_vld = ctrl.insn_vld;

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
  import rv_pkg::*;
();

  localparam int NUM_ROWS     = 12;
  localparam int HOLD_CYCLES  = 64;   // > two passes of the 27-insn loop
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = NUM_ROWS * HOLD_CYCLES + RESET_CYCLES + 200;

  localparam logic [31:0] LOOP_END  = 32'h0000_0068;  // jal back to 0
  localparam logic [31:0] AUIPC_PC  = 32'h0000_005C;  // where auipc sits in rom
  localparam logic [19:0] AUIPC_IMM = 20'h12345;

  logic        i_clk;
  logic        i_reset;
  logic [31:0] i_io_sw;
  board_io_t   o_io;
  logic [31:0] o_pc_debug;
  logic        o_insn_vld;

  logic [31:0] sw_tbl  [NUM_ROWS];  // switch value per row
  board_io_t   exp_tbl [NUM_ROWS];  // expected board state per row
  int          tests  = 0;
  int          errors = 0;
  int          cycles = 0;

  rv_core #(.IMEM_WORDS(256), .DMEM_WORDS(1024)) u_dut (
    .i_clk(i_clk), .i_reset(i_reset), .i_io_sw(i_io_sw),
    .o_io(o_io), .o_pc_debug(o_pc_debug), .o_insn_vld(o_insn_vld)
  );

  always #10 i_clk = ~i_clk;  // 20 ns period

  // ==========================================================================
  // expected board outputs for one switch value
  // ==========================================================================
  function automatic board_io_t expect_io(input logic [31:0] s);
    board_io_t   e;
    logic [31:0] hexhi;
    int          d;
    e      = '0;
    e.ledr = ((s << 3) ^ s) + 32'h0000_1234;
    e.ledg = ($signed(s) < 0) ? 32'd1 : 32'd2;  // blt against x0
    if (s < 32'h0000_0100) e.ledg = 32'd4;       // bltu path
    e.lcd    = {{16{s[15]}}, s[15:0]};           // sh then lh
    e.hex[0] = s[6:0];                           // sb leaves upper digits zero
    hexhi    = {AUIPC_IMM, 12'd0} + AUIPC_PC;
    for (d = 0; d < 4; d++) begin
      e.hex[d+4] = hexhi[8*d +: 7];
    end
    return e;
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_word(input string tag, input string name,
                            input logic [31:0] exp, input logic [31:0] act);
    tests++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s at %s: expected %h, actual %h", name, tag, exp, act);
    end else begin
      $display("ok %s at %s = %h", name, tag, act);
    end
  endtask

  task automatic check_io(input string tag, input board_io_t exp, input board_io_t act);
    int d;
    tests++;
    if (act === exp) begin
      $display("ok o_io at %s", tag);
    end else begin
      errors++;
      if (act.ledr !== exp.ledr)
        $display("mismatch o_io.ledr at %s: expected %h, actual %h", tag, exp.ledr, act.ledr);
      if (act.ledg !== exp.ledg)
        $display("mismatch o_io.ledg at %s: expected %h, actual %h", tag, exp.ledg, act.ledg);
      if (act.lcd !== exp.lcd)
        $display("mismatch o_io.lcd at %s: expected %h, actual %h", tag, exp.lcd, act.lcd);
      for (d = 0; d < 8; d++) begin
        if (act.hex[d] !== exp.hex[d])
          $display("mismatch o_io.hex[%0d] at %s: expected %h, actual %h",
                   d, tag, exp.hex[d], act.hex[d]);
      end
    end
  endtask

  // pc must sit on a word inside the loop
  task automatic check_pc(input string tag, input logic [31:0] pc);
    tests++;
    if ($isunknown(pc) || pc > LOOP_END || pc[1:0] != 2'b00) begin
      errors++;
      $display("%s: o_pc_debug %h is outside the program loop", tag, pc);
    end else begin
      $display("ok o_pc_debug at %s = %h", tag, pc);
    end
  endtask

  // ==========================================================================
  // run limit
  // ==========================================================================
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    int          r;
    logic [31:0] seed_val;
    i_clk    = 1'b0;
    i_reset  = 1'b0;   // reset held from time 0
    i_io_sw  = 32'd0;
    seed_val = $urandom(32'h72eb_031a);

    // corner rows first and random ones after
    sw_tbl[0] = 32'h0000_0000;
    sw_tbl[1] = 32'h0000_00FF;
    sw_tbl[2] = 32'h0000_0100;
    sw_tbl[3] = 32'h0000_8000;
    sw_tbl[4] = 32'hFFFF_FFFF;
    sw_tbl[5] = 32'h8000_0000;
    sw_tbl[6] = 32'h0000_007F;
    for (r = 7; r < NUM_ROWS; r++) begin
      sw_tbl[r] = $urandom;
    end
    for (r = 0; r < NUM_ROWS; r++) begin
      exp_tbl[r] = expect_io(sw_tbl[r]);
    end

    #5;  // still ahead of the first rising edge
    check_io("reset", '0, o_io);
    check_word("reset", "o_pc_debug", 32'd0, o_pc_debug);

    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset = 1'b1;

    for (r = 0; r < NUM_ROWS; r++) begin
      i_io_sw = sw_tbl[r];  // on a falling edge
      repeat (HOLD_CYCLES) @(negedge i_clk);
      check_io($sformatf("row %0d sw=%h", r, sw_tbl[r]), exp_tbl[r], o_io);
      check_word($sformatf("row %0d", r), "o_insn_vld", 32'd1, {31'd0, o_insn_vld});
      check_pc($sformatf("row %0d", r), o_pc_debug);
    end

    // async reset clears a busy board before the next rising edge
    i_reset = 1'b0;
    #5;
    check_io("reset mid-run", '0, o_io);
    check_word("reset mid-run", "o_pc_debug", 32'd0, o_pc_debug);

    $display("tests %0d, errors %0d, seed probe %h", tests, errors, seed_val);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_prog.hex
// instruction rom image, one 32-bit word per line starting at address 0
// columns: machine word, then address and assembly in the comment
100000B7  // 00: lui   x1, 0x10000      switch page base
0000A103  // 04: lw    x2, 0(x1)        s = switches
00311193  // 08: slli  x3, x2, 3
0021C1B3  // 0C: xor   x3, x3, x2
00001237  // 10: lui   x4, 0x1
23420213  // 14: addi  x4, x4, 0x234    x4 = 0x1234
004181B3  // 18: add   x3, x3, x4
100012B7  // 1C: lui   x5, 0x10001      ledr
0032A023  // 20: sw    x3, 0(x5)
00100313  // 24: addi  x6, x0, 1
00014463  // 28: blt   x2, x0, +8       negative keeps 1
00200313  // 2C: addi  x6, x0, 2
10000393  // 30: addi  x7, x0, 0x100
00717463  // 34: bgeu  x2, x7, +8       not below 0x100 skips
00400313  // 38: addi  x6, x0, 4
100022B7  // 3C: lui   x5, 0x10002      ledg
0062A023  // 40: sw    x6, 0(x5)
00201323  // 44: sh    x2, 6(x0)        upper half of ram word 1
00601403  // 48: lh    x8, 6(x0)
100032B7  // 4C: lui   x5, 0x10003      lcd
0082A023  // 50: sw    x8, 0(x5)
100042B7  // 54: lui   x5, 0x10004      hex lo
00228023  // 58: sb    x2, 0(x5)
12345497  // 5C: auipc x9, 0x12345      x9 = 0x1234505C
100052B7  // 60: lui   x5, 0x10005      hex hi
0092A023  // 64: sw    x9, 0(x5)
F99FF06F  // 68: jal   x0, -0x68        back to 00

//--- rv_core.f
rv_pkg.sv
rv_fetch.sv
rv_control.sv
rv_immgen.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build the rv_core testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o tb_rv_core \
  && out="$(./obj_dir/tb_rv_core)" \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
